// ==== hw/vec_pkg.sv ====
`default_nettype none

// shared widths and types for the vector element engine
package vec_pkg;

    // element width in bits
    localparam int data_w = 32;

    // register file address width, which gives 32 elements
    localparam int rf_addr_w = 5;

    // length field width, wide enough to hold 32 itself
    localparam int len_w = 6;

    // opcodes understood by the engine
    typedef enum logic [1:0] {
        op_vle32 = 2'd0,
        op_vse32 = 2'd1,
        op_vmacc = 2'd2
    } vec_op_t;

    // one vector instruction as it arrives on the instruction port
    // the total width is 2 + 5 + 5 + 6 + 32 = 50 bits
    typedef struct packed {
        vec_op_t                op;
        logic [rf_addr_w-1:0]   vs_base;
        logic [rf_addr_w-1:0]   vd_base;
        logic [len_w-1:0]       len;
        logic [data_w-1:0]      scalar;
    } vec_instr_t;

    // sequencer states, idle waits for an instruction and busy walks it
    typedef enum logic {
        st_idle = 1'b0,
        st_busy = 1'b1
    } seq_state_t;

endpackage

`default_nettype wire

// ==== hw/vec_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

// instruction sequencer with separate read and write element counters
module vec_seq import vec_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire vec_instr_t           instr,
    input  wire logic                 instr_valid,
    output logic                      instr_ready,
    input  wire logic                 rd_fire,
    input  wire logic                 wr_fire,
    output logic                      busy,
    output logic                      rd_more,
    output logic                      done,
    output vec_instr_t                cmd,
    output logic [rf_addr_w-1:0]      rd_addr_a,
    output logic [rf_addr_w-1:0]      rd_addr_b,
    output logic [rf_addr_w-1:0]      wr_addr
);

    seq_state_t          state_q;
    seq_state_t          state_d;
    vec_instr_t          cmd_q;
    logic [len_w-1:0]    last_idx;
    logic [len_w-1:0]    rd_cnt;
    logic [len_w-1:0]    wr_cnt;
    logic                accept;

    // an instruction is only taken while nothing is in flight
    assign instr_ready = (state_q == st_idle);
    assign accept      = instr_valid && instr_ready;
    assign busy        = (state_q == st_busy);

    // the last write of the instruction ends it for every opcode,
    // since vse32 also counts an output transfer as a write
    assign done = busy && wr_fire && (wr_cnt == last_idx);

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: if (accept) state_d = st_busy;
            st_busy: if (done) state_d = st_idle;
            default: state_d = st_idle;
        endcase
    end

    // the instruction and its last index are captured on acceptance
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= st_idle;
            cmd_q    <= '0;
            last_idx <= '0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                cmd_q    <= instr;
                last_idx <= instr.len - 1'b1;
            end
        end
    end

    // the read counter only moves when the producer takes an element,
    // so it holds its value while the FIFO or the input stream stalls
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_cnt <= '0;
        end else if (accept) begin
            rd_cnt <= '0;
        end else if (rd_fire) begin
            rd_cnt <= rd_cnt + 1'b1;
        end
    end

    // the write counter follows the consumer side in the same way
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_cnt <= '0;
        end else if (accept) begin
            wr_cnt <= '0;
        end else if (wr_fire) begin
            wr_cnt <= wr_cnt + 1'b1;
        end
    end

    // reads are left while the counter has not gone past the last index
    assign rd_more = busy && (rd_cnt <= last_idx);

    assign cmd = cmd_q;

    // addresses wrap modulo 32 because only the low counter bits are added
    assign rd_addr_a = cmd_q.vs_base + rd_cnt[rf_addr_w-1:0];
    assign rd_addr_b = cmd_q.vd_base + rd_cnt[rf_addr_w-1:0];
    assign wr_addr   = cmd_q.vd_base + wr_cnt[rf_addr_w-1:0];

    // a zero length would never reach the last index and hang the engine
    a_len_nonzero: assert property (@(posedge clk) disable iff (rst)
        accept |-> (instr.len != '0));

    // the producer must stop once every element has been fetched
    a_rd_in_range: assert property (@(posedge clk) disable iff (rst)
        rd_fire |-> rd_more);

    // the consumer must not see a stray element between instructions
    a_wr_when_busy: assert property (@(posedge clk) disable iff (rst)
        wr_fire |-> busy);

endmodule

`default_nettype wire

// ==== hw/vec_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

// element register file with two read ports and one write port
module vec_regfile import vec_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic [rf_addr_w-1:0]  rd_addr_a,
    input  wire logic [rf_addr_w-1:0]  rd_addr_b,
    input  wire logic [rf_addr_w-1:0]  wr_addr,
    input  wire logic                  we,
    input  wire logic [data_w-1:0]     wr_data,
    output logic [data_w-1:0]          rd_data_a,
    output logic [data_w-1:0]          rd_data_b
);

    localparam int n_elem = 1 << rf_addr_w;

    logic [data_w-1:0] mem [n_elem];

    // every entry starts at zero so the contents are known after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < n_elem; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // port a serves the source operand and port b the old destination
    // value for vmacc, both without a cycle of latency
    assign rd_data_a = mem[rd_addr_a];
    assign rd_data_b = mem[rd_addr_b];

endmodule

`default_nettype wire

// ==== hw/vec_operand_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

// producer stage that fetches operands and computes one element per transfer
module vec_operand_stage import vec_pkg::*; (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire vec_instr_t          cmd,
    input  wire logic                busy,
    input  wire logic                rd_more,
    input  wire logic [data_w-1:0]   rd_data_a,
    input  wire logic [data_w-1:0]   rd_data_b,
    input  wire logic [data_w-1:0]   in_data,
    input  wire logic                in_valid,
    output logic                     in_ready,
    output logic                     rd_fire,
    output logic                     push_valid,
    output logic [data_w-1:0]        push_data,
    input  wire logic                push_ready
);

    logic                slot_free;
    logic                can_read;
    logic                is_load;
    logic [data_w-1:0]   product;
    logic [data_w-1:0]   elem_next;
    logic [data_w-1:0]   elem_q;

    // the held element may be replaced in the cycle it leaves,
    // which keeps one element per cycle flowing without a bubble
    assign slot_free = !push_valid || push_ready;
    assign can_read  = busy && rd_more && slot_free;
    assign is_load   = (cmd.op == op_vle32);

    // a load also has to wait for a word on the input stream
    assign in_ready = can_read && is_load;
    assign rd_fire  = can_read && (!is_load || in_valid);

    // only the low 32 bits of the product are kept
    assign product = rd_data_a * cmd.scalar;

    always_comb begin
        case (cmd.op)
            op_vle32: elem_next = in_data;
            op_vse32: elem_next = rd_data_a;
            op_vmacc: elem_next = rd_data_b + product;
            default:  elem_next = rd_data_a;
        endcase
    end

    // valid is registered so it never depends on the FIFO's ready
    always_ff @(posedge clk) begin
        if (rst) begin
            push_valid <= 1'b0;
        end else if (rd_fire) begin
            push_valid <= 1'b1;
        end else if (push_ready) begin
            push_valid <= 1'b0;
        end
    end

    // the element itself only changes when a new one is taken
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            elem_q <= elem_next;
        end
    end

    assign push_data = elem_q;

endmodule

`default_nettype wire

// ==== hw/vec_elem_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

// circular element buffer between the producer and the consumer
module vec_elem_fifo import vec_pkg::*; #(
    parameter int DEPTH = 4
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic [data_w-1:0]   push_data,
    input  wire logic                push_valid,
    output logic                     push_ready,
    output logic                     pop_valid,
    output logic [data_w-1:0]        pop_data,
    input  wire logic                pop_ready
);

    localparam int ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int cnt_w = $clog2(DEPTH + 1);
    localparam logic [cnt_w-1:0] full_cnt = cnt_w'(DEPTH);
    localparam logic [ptr_w-1:0] last_ptr = ptr_w'(DEPTH - 1);

    logic [data_w-1:0]   mem [DEPTH];
    logic [ptr_w-1:0]    wr_ptr;
    logic [ptr_w-1:0]    rd_ptr;
    logic [cnt_w-1:0]    count;
    logic                push_fire;
    logic                pop_fire;

    // a full buffer still takes a push when the head leaves in the same cycle
    assign push_ready = (count != full_cnt) || pop_ready;
    assign push_fire  = push_valid && push_ready;

    // the head comes straight from the stored entry, so valid rises
    // one cycle after a push into an empty buffer
    assign pop_valid = (count != '0);
    assign pop_data  = mem[rd_ptr];
    assign pop_fire  = pop_valid && pop_ready;

    always_ff @(posedge clk) begin
        if (push_fire) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers wrap explicitly so a depth that is not a power of two works
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_fire) begin
                rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
            end
            if (push_fire && !pop_fire) begin
                count <= count + 1'b1;
            end else if (pop_fire && !push_fire) begin
                count <= count - 1'b1;
            end
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (rst)
        count <= full_cnt);

    // the pointers meet whenever the count says empty, so no stale entry
    // can ever be taken as the head
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        (count == '0) |-> (rd_ptr == wr_ptr));

endmodule

`default_nettype wire

// ==== hw/vec_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

// consumer stage that sends each element to the file or to the output stream
module vec_writeback import vec_pkg::*; (
    input  wire vec_instr_t          cmd,
    input  wire logic                pop_valid,
    input  wire logic [data_w-1:0]   pop_data,
    output logic                     pop_ready,
    output logic                     wr_fire,
    output logic                     we,
    output logic [data_w-1:0]        wr_data,
    output logic [data_w-1:0]        out_data,
    output logic                     out_valid,
    input  wire logic                out_ready
);

    logic is_store;

    // vse32 is the only opcode whose result leaves the engine
    assign is_store = (cmd.op == op_vse32);

    // the file can always take a write, so only the output stream
    // pushes back into the FIFO
    assign pop_ready = is_store ? out_ready : 1'b1;

    // out_valid comes from the FIFO alone and never from out_ready
    assign out_valid = is_store && pop_valid;
    assign out_data  = pop_data;

    // vle32 and vmacc write the popped element at the sequencer's
    // write address in the same cycle as the pop
    assign we      = !is_store && pop_valid;
    assign wr_data = pop_data;

    // a completed element is either a file write or an output transfer,
    // which is exactly a pop in both cases
    assign wr_fire = pop_valid && pop_ready;

endmodule

`default_nettype wire

// ==== hw/vec_engine_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// vector element engine, sequencer plus producer, FIFO and consumer
module vec_engine_top import vec_pkg::*; #(
    parameter int DEPTH = 4
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire vec_instr_t          instr,
    input  wire logic                instr_valid,
    output logic                     instr_ready,
    input  wire logic [data_w-1:0]   in_data,
    input  wire logic                in_valid,
    output logic                     in_ready,
    output logic [data_w-1:0]        out_data,
    output logic                     out_valid,
    input  wire logic                out_ready,
    output logic                     done
);

    vec_instr_t             cmd;
    logic                   busy;
    logic                   rd_more;
    logic                   rd_fire;
    logic                   wr_fire;
    logic [rf_addr_w-1:0]   rd_addr_a;
    logic [rf_addr_w-1:0]   rd_addr_b;
    logic [rf_addr_w-1:0]   wr_addr;
    logic [data_w-1:0]      rd_data_a;
    logic [data_w-1:0]      rd_data_b;
    logic [data_w-1:0]      push_data;
    logic                   push_valid;
    logic                   push_ready;
    logic [data_w-1:0]      pop_data;
    logic                   pop_valid;
    logic                   pop_ready;
    logic                   we;
    logic [data_w-1:0]      wr_data;

    vec_seq vec_seq_inst (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .rd_fire     (rd_fire),
        .wr_fire     (wr_fire),
        .busy        (busy),
        .rd_more     (rd_more),
        .done        (done),
        .cmd         (cmd),
        .rd_addr_a   (rd_addr_a),
        .rd_addr_b   (rd_addr_b),
        .wr_addr     (wr_addr)
    );

    vec_regfile vec_regfile_inst (
        .clk       (clk),
        .rst       (rst),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .wr_addr   (wr_addr),
        .we        (we),
        .wr_data   (wr_data),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b)
    );

    vec_operand_stage vec_operand_stage_inst (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd),
        .busy       (busy),
        .rd_more    (rd_more),
        .rd_data_a  (rd_data_a),
        .rd_data_b  (rd_data_b),
        .in_data    (in_data),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .rd_fire    (rd_fire),
        .push_valid (push_valid),
        .push_data  (push_data),
        .push_ready (push_ready)
    );

    // the buffer depth is the only parameter passed down
    vec_elem_fifo #(
        .DEPTH (DEPTH)
    ) vec_elem_fifo_inst (
        .clk        (clk),
        .rst        (rst),
        .push_data  (push_data),
        .push_valid (push_valid),
        .push_ready (push_ready),
        .pop_valid  (pop_valid),
        .pop_data   (pop_data),
        .pop_ready  (pop_ready)
    );

    vec_writeback vec_writeback_inst (
        .cmd       (cmd),
        .pop_valid (pop_valid),
        .pop_data  (pop_data),
        .pop_ready (pop_ready),
        .wr_fire   (wr_fire),
        .we        (we),
        .wr_data   (wr_data),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

// ==== bench/vec_engine_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

// self-checking testbench for the vector element engine
module vec_engine_tb import vec_pkg::*; ();

    // each element may take several cycles under random gaps and stalls,
    // so the limit grows with the elements walked by all instructions
    localparam int total_len   = 8 + 8 + 4 * 12 + 10 + 10 + 14 + 32;
    localparam int cycle_limit = total_len * 8 + 200;
    localparam int n_instr     = 10;

    logic                clk = 1'b0;
    logic                rst = 1'b1;
    vec_instr_t          instr = '0;
    logic                instr_valid = 1'b0;
    logic                instr_ready;
    logic [data_w-1:0]   in_data = '0;
    logic                in_valid = 1'b0;
    logic                in_ready;
    logic [data_w-1:0]   out_data;
    logic                out_valid;
    logic                out_ready = 1'b0;
    logic                done;

    // mirror of the register file and the stream bookkeeping
    logic [31:0]   model [32];
    logic [31:0]   in_words [128];
    logic [31:0]   exp_q [$];
    logic [31:0]   exp_word;
    int            exp_total = 0;
    int            out_cnt = 0;
    int            in_total = 0;
    int            in_idx = 0;
    int            next_idx;
    logic          in_take = 1'b0;

    // both random streams start from the same seed
    logic [31:0]   data_state = 32'd97;
    logic [31:0]   gap_state = 32'd97;

    // engine state as the bench expects it to be
    logic          bench_busy = 1'b0;
    vec_op_t       cur_op = op_vle32;
    int            n_acc = 0;
    int            done_cnt = 0;
    int            cyc = 0;
    int            hold_from = 0;
    int            hold_until = 0;

    always #4 clk = ~clk;

    vec_engine_top #(
        .DEPTH (4)
    ) vec_engine_top_inst (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .in_data     (in_data),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .done        (done)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    function logic [31:0] next_word();
        data_state = lcg_step(data_state);
        return data_state;
    endfunction

    // walks one instruction over the model in program order, appends the
    // words a store should stream out and returns how many it added
    function automatic int ref_model(input vec_op_t op, input int vs, input int vd,
                                     input int len, input logic [31:0] scalar,
                                     input int in_first);
        int s;
        int d;
        int n_out;
        n_out = 0;
        for (int i = 0; i < len; i++) begin
            s = (vs + i) % 32;
            d = (vd + i) % 32;
            case (op)
                op_vle32: model[d] = in_words[in_first + i];
                op_vse32: begin
                    exp_q.push_back(model[s]);
                    n_out++;
                end
                default: model[d] = model[d] + model[s] * scalar;
            endcase
        end
        return n_out;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    // prepares the model and the input words, then offers the instruction
    // until the engine takes it
    task automatic send_instr(input vec_op_t op, input int vs, input int vd,
                              input int len, input logic [31:0] scalar);
        vec_instr_t ins;
        ins.op      = op;
        ins.vs_base = rf_addr_w'(vs);
        ins.vd_base = rf_addr_w'(vd);
        ins.len     = len_w'(len);
        ins.scalar  = scalar;
        @(negedge clk);
        if (op == op_vle32) begin
            for (int i = 0; i < len; i++) begin
                in_words[in_total + i] = next_word();
            end
        end
        exp_total += ref_model(op, vs, vd, len, scalar, in_total);
        if (op == op_vle32) begin
            in_total += len;
        end
        @(posedge clk);
        instr       <= ins;
        instr_valid <= 1'b1;
        @(negedge clk);
        while (!instr_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        instr_valid <= 1'b0;
    endtask

    // the input stream and the output back-pressure both see random gaps
    always @(posedge clk) begin
        if (rst) begin
            in_valid  <= 1'b0;
            out_ready <= 1'b0;
        end else begin
            gap_state = lcg_step(gap_state);
            next_idx  = in_take ? in_idx + 1 : in_idx;
            in_idx   <= next_idx;
            // a word that has not transferred stays on the bus unchanged
            if (in_valid && !in_take) begin
                in_valid <= 1'b1;
            end else if (next_idx < in_total && gap_state[20]) begin
                in_valid <= 1'b1;
                in_data  <= in_words[next_idx];
            end else begin
                in_valid <= 1'b0;
            end
            if (cyc >= hold_from && cyc < hold_until) begin
                out_ready <= 1'b0;
            end else begin
                out_ready <= gap_state[27];
            end
        end
    end

    // handshakes are sampled at the falling edge because every signal is stable there
    always @(negedge clk) begin
        if (!rst && out_valid && out_ready) begin
            assert (exp_q.size() != 0)
                else stop_run("an output word arrived when none was expected");
            exp_word = exp_q.pop_front();
            assert (out_data == exp_word)
                else stop_run($sformatf("[ERROR] %0t ns out_data got %h expected %h",
                                        $time, out_data, exp_word));
            out_cnt++;
        end
    end

    // control checks where the busy window runs from acceptance to done
    always @(negedge clk) begin
        if (rst) begin
            in_take = 1'b0;
        end else begin
            in_take = in_valid && in_ready;
            assert (instr_ready == !bench_busy)
                else stop_run($sformatf("[ERROR] %0t ns instr_ready got %b expected %b",
                                        $time, instr_ready, !bench_busy));
            assert (!done || bench_busy)
                else stop_run("done pulsed while no instruction was in flight");
            // only a running vle32 may ask for input words
            assert (!in_ready || (bench_busy && cur_op == op_vle32))
                else stop_run($sformatf("[ERROR] %0t ns in_ready got %b expected %b",
                                        $time, in_ready, 1'b0));
            if (instr_valid && instr_ready) begin
                bench_busy = 1'b1;
                cur_op     = instr.op;
                n_acc++;
            end else if (done) begin
                bench_busy = 1'b0;
                done_cnt++;
            end
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= cycle_limit) begin
            stop_run("the run did not finish in time, the engine seems stuck");
        end
    end

    initial begin
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        // load and stream back one region
        send_instr(op_vle32, 0, 3, 8, '0);
        send_instr(op_vse32, 3, 0, 8, '0);
        // multiply-accumulate over two freshly loaded regions
        send_instr(op_vle32, 0, 20, 12, '0);
        send_instr(op_vle32, 0, 8, 12, '0);
        send_instr(op_vmacc, 20, 8, 12, next_word());
        send_instr(op_vse32, 8, 0, 12, '0);
        // a region that wraps past the top of the file
        send_instr(op_vle32, 0, 28, 10, '0);
        send_instr(op_vse32, 28, 0, 10, '0);
        send_instr(op_vse32, 6, 0, 14, '0);
        // full-length store with a long output stall in the middle
        send_instr(op_vse32, 0, 0, 32, '0);
        @(negedge clk);
        hold_from  = cyc + 4;
        hold_until = hold_from + 20;
        while (done_cnt != n_instr) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        if (exp_q.size() == 0 && out_cnt == exp_total && in_idx == in_total
                && n_acc == n_instr) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            stop_run("words or instructions are missing at the end of the run");
        end
    end

endmodule

`default_nettype wire

// ==== vec_engine.f ====
hw/vec_pkg.sv
hw/vec_seq.sv
hw/vec_regfile.sv
hw/vec_operand_stage.sv
hw/vec_elem_fifo.sv
hw/vec_writeback.sv
hw/vec_engine_top.sv
bench/vec_engine_tb.sv

// ==== Makefile ====
SIM  := obj_dir/Vvec_engine_tb
SRCS := hw/vec_pkg.sv hw/vec_seq.sv hw/vec_regfile.sv hw/vec_operand_stage.sv \
        hw/vec_elem_fifo.sv hw/vec_writeback.sv hw/vec_engine_top.sv \
        bench/vec_engine_tb.sv

.PHONY: all run clean

all: run

# the simulator binary is rebuilt only when a source or the file list changes
$(SIM): vec_engine.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module vec_engine_tb -f vec_engine.f

# the log decides the result, so a missing pass line fails the target
run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
